// ==== common/csr_macros.svh ====
`ifndef CSR_MACROS_SVH
`define CSR_MACROS_SVH

`define CSR_DATA_W   32
`define CSR_TIMER_W  32
`define CSR_NUM_W    14
`define CSR_ECODE_W  6
`define CSR_ESUB_W   9

// csr numbers
`define CSR_CRMD     14'h000
`define CSR_PRMD     14'h001
`define CSR_ECFG     14'h004
`define CSR_ESTAT    14'h005
`define CSR_ERA      14'h006
`define CSR_BADV     14'h007
`define CSR_EENTRY   14'h00c
`define CSR_SAVE0    14'h030
`define CSR_SAVE1    14'h031
`define CSR_SAVE2    14'h032
`define CSR_SAVE3    14'h033
`define CSR_TID      14'h040
`define CSR_TCFG     14'h041
`define CSR_TVAL     14'h042
`define CSR_TICLR    14'h044

`define ECODE_INT    6'h00
`define ECODE_ADE    6'h08
`define ECODE_ALE    6'h09
`define ECODE_SYS    6'h0b

`define CRMD_RESET   9'h008  // DA=1, PLV0, IE off

`endif

// ==== common/csr_pkg.sv ====
`include "csr_macros.svh"

package csr_pkg;

    typedef enum logic [2:0] {
        OP_NONE = 3'd0,
        OP_RD   = 3'd1,
        OP_WR   = 3'd2,
        OP_XCHG = 3'd3,
        OP_EXCP = 3'd4,
        OP_ERTN = 3'd5
    } csr_op_e;

    // arg word seen as a csr number
    typedef struct packed {
        logic [1:0]            pad;
        logic [`CSR_NUM_W-1:0] csr_num;
    } csr_num_view_t;

    // arg word seen as exception cause
    typedef struct packed {
        logic                    pad;
        logic [`CSR_ESUB_W-1:0]  esubcode;
        logic [`CSR_ECODE_W-1:0] ecode;
    } csr_excp_view_t;

    typedef union packed {
        csr_num_view_t  num;
        csr_excp_view_t excp;
    } csr_arg_u;

    typedef struct packed {
        logic                   valid;
        csr_op_e                op;
        csr_arg_u               arg;
        logic [`CSR_DATA_W-1:0] wdata;
        logic [`CSR_DATA_W-1:0] mask;
        logic [`CSR_DATA_W-1:0] pc;
        logic [`CSR_DATA_W-1:0] badv;  // faulting address
    } csr_req_t;

    typedef struct packed {
        logic                    valid;
        csr_op_e                 op;       // interrupts show up as OP_EXCP
        logic [`CSR_NUM_W-1:0]   csr_num;
        logic [`CSR_ECODE_W-1:0] ecode;
        logic [`CSR_ESUB_W-1:0]  esubcode;
        logic [`CSR_DATA_W-1:0]  wdata;    // already merged
        logic [`CSR_DATA_W-1:0]  pc;
        logic [`CSR_DATA_W-1:0]  badv;
    } csr_commit_t;

    typedef struct packed {
        logic                   flush;
        logic [`CSR_DATA_W-1:0] target;
    } csr_redirect_t;

endpackage

// ==== csr/csr_commit_stage.sv ====
`timescale 1ns/100ps
`include "csr_macros.svh"

module csr_commit_stage import csr_pkg::*; (
    input  logic                   clk,
    input  logic                   rstn,
    input  csr_commit_t            entry,
    input  logic [`CSR_NUM_W-1:0]  rd_num,
    output logic [`CSR_DATA_W-1:0] rd_value,
    output logic                   irq_pending,
    output logic [`CSR_DATA_W-1:0] crmd,
    output logic [`CSR_DATA_W-1:0] era,
    output logic [`CSR_DATA_W-1:0] eentry
);

    localparam logic [12:0] ECFG_LIE_MASK = 13'h1bff;  // bit 10 reserved

    logic [8:0]                    crmd_q;
    logic [2:0]                    prmd_q;
    logic [12:0]                   ecfg_q;
    logic [1:0]                    estat_is;
    logic [`CSR_ECODE_W-1:0]       estat_ecode;
    logic [`CSR_ESUB_W-1:0]        estat_esub;
    logic [`CSR_DATA_W-1:0]        era_q;
    logic [`CSR_DATA_W-1:0]        badv_q;
    logic [`CSR_DATA_W-1:6]        eentry_q;
    logic [`CSR_DATA_W-1:0]        save_q [4];
    logic [`CSR_DATA_W-1:0]        tid_q;
    logic [`CSR_DATA_W-1:0]        estat_val;

    logic                          csr_we;
    logic                          do_excp;
    logic                          do_ertn;
    logic                          tcfg_we;
    logic                          ti_clear;
    logic                          ti_flag;
    logic [`CSR_TIMER_W-1:0]       tcfg;
    logic [`CSR_TIMER_W-1:0]       tval;

    assign csr_we  = entry.valid && (entry.op == OP_WR || entry.op == OP_XCHG);
    assign do_excp = entry.valid && (entry.op == OP_EXCP);
    assign do_ertn = entry.valid && (entry.op == OP_ERTN);

    assign tcfg_we  = csr_we && (entry.csr_num == `CSR_TCFG);
    assign ti_clear = csr_we && (entry.csr_num == `CSR_TICLR) && entry.wdata[0];

    csr_timer u_timer (
        .clk        (clk),
        .rstn       (rstn),
        .tcfg_we    (tcfg_we),
        .tcfg_wdata (entry.wdata),
        .ti_clear   (ti_clear),
        .ti_flag    (ti_flag),
        .tcfg       (tcfg),
        .tval       (tval)
    );

    // esubcode, ecode, TI at 11, SWI at 1:0
    assign estat_val = {1'b0, estat_esub, estat_ecode, 4'b0, ti_flag, 9'b0, estat_is};

    assign irq_pending = crmd_q[2] && |(estat_val[12:0] & ecfg_q);

    assign crmd   = {23'b0, crmd_q};
    assign era    = era_q;
    assign eentry = {eentry_q, 6'b0};

    always_comb
    begin
        case (rd_num)
            `CSR_CRMD:   rd_value = {23'b0, crmd_q};
            `CSR_PRMD:   rd_value = {29'b0, prmd_q};
            `CSR_ECFG:   rd_value = {19'b0, ecfg_q};
            `CSR_ESTAT:  rd_value = estat_val;
            `CSR_ERA:    rd_value = era_q;
            `CSR_BADV:   rd_value = badv_q;
            `CSR_EENTRY: rd_value = {eentry_q, 6'b0};
            `CSR_SAVE0, `CSR_SAVE1, `CSR_SAVE2, `CSR_SAVE3:
                rd_value = save_q[rd_num[1:0]];
            `CSR_TID:    rd_value = tid_q;
            `CSR_TCFG:   rd_value = tcfg;
            `CSR_TVAL:   rd_value = tval;
            default:     rd_value = '0;  // TICLR and unknown numbers
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            crmd_q      <= `CRMD_RESET;
            prmd_q      <= '0;
            ecfg_q      <= '0;
            estat_is    <= '0;
            estat_ecode <= '0;
            estat_esub  <= '0;
            era_q       <= '0;
            badv_q      <= '0;
            eentry_q    <= '0;
            tid_q       <= '0;
            for (int i = 0; i < 4; i++)
                save_q[i] <= '0;
        end
        else if (do_excp)
        begin
            prmd_q      <= crmd_q[2:0];
            crmd_q[2:0] <= 3'b000;  // kernel, interrupts masked
            era_q       <= entry.pc;
            estat_ecode <= entry.ecode;
            estat_esub  <= entry.esubcode;
            if (entry.ecode == `ECODE_ADE || entry.ecode == `ECODE_ALE)
                badv_q <= entry.badv;
        end
        else if (do_ertn)
        begin
            crmd_q[2:0] <= prmd_q;
        end
        else if (csr_we)
        begin
            case (entry.csr_num)
                `CSR_CRMD:   crmd_q   <= entry.wdata[8:0];
                `CSR_PRMD:   prmd_q   <= entry.wdata[2:0];
                `CSR_ECFG:   ecfg_q   <= entry.wdata[12:0] & ECFG_LIE_MASK;
                `CSR_ESTAT:  estat_is <= entry.wdata[1:0];  // only the sw bits
                `CSR_ERA:    era_q    <= entry.wdata;
                `CSR_BADV:   badv_q   <= entry.wdata;
                `CSR_EENTRY: eentry_q <= entry.wdata[`CSR_DATA_W-1:6];
                `CSR_SAVE0, `CSR_SAVE1, `CSR_SAVE2, `CSR_SAVE3:
                    save_q[entry.csr_num[1:0]] <= entry.wdata;
                `CSR_TID:    tid_q    <= entry.wdata;
                default:     ;
            endcase
        end
    end

    // exception and return entries never arrive back to back
    a_excp_ertn_apart: assert property (@(posedge clk) disable iff (!rstn)
        (do_excp || do_ertn) |=> !do_excp && !do_ertn);

endmodule

// ==== csr/csr_issue_stage.sv ====
`timescale 1ns/100ps
`include "csr_macros.svh"

module csr_issue_stage import csr_pkg::*; (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   stall,
    input  csr_req_t               req,
    input  logic                   irq_pending,
    input  logic [`CSR_DATA_W-1:0] rd_value,
    input  logic [`CSR_DATA_W-1:0] era,
    input  logic [`CSR_DATA_W-1:0] eentry,
    output csr_commit_t            entry,
    output csr_redirect_t          redirect,
    output logic [`CSR_DATA_W-1:0] rdata,
    output logic                   excp_flush,
    output logic                   ertn_flush
);

    logic                   take_irq;
    logic                   take_req;
    logic [`CSR_DATA_W-1:0] wmask;
    csr_commit_t            entry_d;
    csr_redirect_t          redirect_d;

    // IE only drops once the entry commits, so hold off while one is in flight
    assign take_irq = irq_pending && !stall && !entry.valid;
    assign take_req = req.valid && !stall && !take_irq;

    assign wmask = (req.op == OP_WR) ? '1 : req.mask;

    always_comb
    begin
        entry_d       = '0;
        entry_d.pc    = req.pc;  // also ERA for a taken interrupt
        entry_d.badv  = req.badv;
        entry_d.wdata = (req.wdata & wmask) | (rd_value & ~wmask);
        if (take_irq)
        begin
            entry_d.valid    = 1'b1;
            entry_d.op       = OP_EXCP;
            entry_d.ecode    = `ECODE_INT;
            entry_d.esubcode = '0;
        end
        else if (take_req)
        begin
            entry_d.valid = (req.op != OP_NONE);
            entry_d.op    = req.op;
            if (req.op == OP_EXCP)
            begin
                entry_d.ecode    = req.arg.excp.ecode;
                entry_d.esubcode = req.arg.excp.esubcode;
            end
            else
            begin
                entry_d.csr_num = req.arg.num.csr_num;
            end
        end
    end

    always_comb
    begin
        redirect_d.flush  = 1'b0;
        redirect_d.target = req.pc + 4;
        if (entry_d.valid)
        begin
            case (entry_d.op)
                OP_EXCP:
                begin
                    redirect_d.flush  = 1'b1;
                    redirect_d.target = eentry;
                end
                OP_ERTN:
                begin
                    redirect_d.flush  = 1'b1;
                    redirect_d.target = era;
                end
                OP_WR, OP_XCHG:
                    redirect_d.flush = 1'b1;  // state may change under later insts
                default:
                    redirect_d.flush = 1'b0;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            entry      <= '0;
            redirect   <= '0;
            excp_flush <= 1'b0;
            ertn_flush <= 1'b0;
        end
        else
        begin
            entry      <= entry_d;
            redirect   <= redirect_d;
            excp_flush <= entry_d.valid && (entry_d.op == OP_EXCP);
            ertn_flush <= entry_d.valid && (entry_d.op == OP_ERTN);
        end
    end

    // old value for rd and xchg
    always_ff @(posedge clk)
    begin
        if (entry_d.valid && (entry_d.op == OP_RD || entry_d.op == OP_XCHG))
            rdata <= rd_value;
        else
            rdata <= '0;
    end

    // no second flush pulse right behind the first one
    a_flush_pulses: assert property (@(posedge clk) disable iff (!rstn)
        (excp_flush || ertn_flush) |=> !excp_flush && !ertn_flush);

endmodule

// ==== csr/csr_timer.sv ====
`timescale 1ns/100ps
`include "csr_macros.svh"

module csr_timer import csr_pkg::*; (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    tcfg_we,
    input  logic [`CSR_TIMER_W-1:0] tcfg_wdata,
    input  logic                    ti_clear,
    output logic                    ti_flag,
    output logic [`CSR_TIMER_W-1:0] tcfg,
    output logic [`CSR_TIMER_W-1:0] tval
);

    logic                    en;
    logic                    periodic;
    logic                    tval_load;
    logic [`CSR_TIMER_W-1:0] init_val;

    assign en       = tcfg[0];
    assign periodic = tcfg[1];
    assign init_val = {tcfg[`CSR_TIMER_W-1:2], 2'b00};

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            tcfg      <= '0;
            tval_load <= 1'b0;
        end
        else
        begin
            tval_load <= tcfg_we && tcfg_wdata[0];  // reload one edge after the write
            if (tcfg_we)
                tcfg <= tcfg_wdata;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rstn)
            tval <= '0;
        else if (tval_load)
            tval <= init_val;
        else if (en)
        begin
            if (tval != '0)
                tval <= tval - `CSR_TIMER_W'(1);
            else if (periodic)
                tval <= init_val;
        end
    end

    // sticky until cleared through TICLR
    always_ff @(posedge clk)
    begin
        if (!rstn)
            ti_flag <= 1'b0;
        else if (ti_clear)
            ti_flag <= 1'b0;
        else if (en && !tval_load && tval == 1)
            ti_flag <= 1'b1;
    end

    a_tval_frozen: assert property (@(posedge clk) disable iff (!rstn)
        (!en && !tcfg_we) |=> $stable(tval));

endmodule

// ==== filelist.f ====
+incdir+common
common/csr_pkg.sv
csr/csr_timer.sv
csr/csr_commit_stage.sv
csr/csr_issue_stage.sv
logic/csr_top.sv
tests/tb_csr_top.sv

// ==== logic/csr_top.sv ====
`timescale 1ns/100ps
`include "csr_macros.svh"

module csr_top import csr_pkg::*; (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   stall,
    input  csr_req_t               req,
    output csr_redirect_t          redirect,
    output logic [`CSR_DATA_W-1:0] rdata,
    output logic                   excp_flush,
    output logic                   ertn_flush,
    output logic [`CSR_DATA_W-1:0] crmd
);

    csr_commit_t            entry;
    logic                   irq_pending;
    logic [`CSR_NUM_W-1:0]  rd_num;
    logic [`CSR_DATA_W-1:0] rd_value;
    logic [`CSR_DATA_W-1:0] era;
    logic [`CSR_DATA_W-1:0] eentry;

    assign rd_num = req.arg.num.csr_num;  // read port follows the incoming request

    csr_issue_stage u_issue (
        .clk         (clk),
        .rstn        (rstn),
        .stall       (stall),
        .req         (req),
        .irq_pending (irq_pending),
        .rd_value    (rd_value),
        .era         (era),
        .eentry      (eentry),
        .entry       (entry),
        .redirect    (redirect),
        .rdata       (rdata),
        .excp_flush  (excp_flush),
        .ertn_flush  (ertn_flush)
    );

    csr_commit_stage u_commit (
        .clk         (clk),
        .rstn        (rstn),
        .entry       (entry),
        .rd_num      (rd_num),
        .rd_value    (rd_value),
        .irq_pending (irq_pending),
        .crmd        (crmd),
        .era         (era),
        .eentry      (eentry)
    );

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the CSR testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f --top-module tb_csr_top \
    -Mdir obj_dir -o tb_csr_top
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/tb_csr_top 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "TEST OK"; then
    exit 0
fi
echo "pass message not found"
exit 1

// ==== tests/tb_csr_top.sv ====
`timescale 1ns/100ps
`include "csr_macros.svh"

module tb_csr_top import csr_pkg::*; ();

    localparam int          NUM_REQ      = 400;
    localparam int          TIMER_INIT   = 32;  // one-shot countdown length
    localparam int          TIMER_BUDGET = 200;
    localparam int          CYCLE_LIMIT  = 20 * NUM_REQ + TIMER_BUDGET;
    localparam logic [31:0] IDLE_PC      = 32'h1c00_8000;
    localparam logic [13:0] KEPT_NUMS [15] = '{
        `CSR_CRMD, `CSR_PRMD, `CSR_ECFG, `CSR_ESTAT, `CSR_ERA, `CSR_BADV, `CSR_EENTRY,
        `CSR_SAVE0, `CSR_SAVE1, `CSR_SAVE2, `CSR_SAVE3, `CSR_TID, `CSR_TCFG, `CSR_TVAL,
        `CSR_TICLR
    };

    logic          clk;
    logic          rstn;
    logic          stall;
    csr_req_t      req;
    csr_redirect_t redirect;
    logic [31:0]   rdata;
    logic          excp_flush;
    logic          ertn_flush;
    logic [31:0]   crmd;
    int            cycle_count = 0;

    // reference copy of the architectural state
    logic [31:0] m_crmd     = 32'(`CRMD_RESET);
    logic [31:0] m_prmd     = '0;
    logic [31:0] m_ecfg     = '0;
    logic [31:0] m_estat_is = '0;
    logic [31:0] m_ecode    = '0;
    logic [31:0] m_esub     = '0;
    logic [31:0] m_era      = '0;
    logic [31:0] m_badv     = '0;
    logic [31:0] m_eentry   = '0;
    logic [31:0] m_save [4] = '{default: '0};
    logic [31:0] m_tid      = '0;
    logic [31:0] m_tcfg     = '0;
    logic        m_ti       = 1'b0;

    csr_top UUT (
        .clk        (clk),
        .rstn       (rstn),
        .stall      (stall),
        .req        (req),
        .redirect   (redirect),
        .rdata      (rdata),
        .excp_flush (excp_flush),
        .ertn_flush (ertn_flush),
        .crmd       (crmd)
    );

    always #50 clk = ~clk;

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT)
        begin
            $display("run did not finish within %0d cycles", CYCLE_LIMIT);
            abort_run();
        end
    end

    task automatic abort_run();
        $display("TEST FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic compare_redirect(input string name, input csr_redirect_t got,
                                    input csr_redirect_t exp);
        if (got !== exp)
        begin
            $display("FAILED at %0t: %s got flush=%0b target=%h, expected flush=%0b target=%h",
                     $time, name, got.flush, got.target, exp.flush, exp.target);
            abort_run();
        end
    endtask

    task automatic compare_data(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("FAILED at %0t: %s got %h, expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic compare_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("FAILED at %0t: %s got %b, expected %b", $time, name, got, exp);
            abort_run();
        end
    endtask

    function automatic logic [31:0] model_read(input logic [13:0] num);
        case (num)
            `CSR_CRMD:   return m_crmd;
            `CSR_PRMD:   return m_prmd;
            `CSR_ECFG:   return m_ecfg;
            `CSR_ESTAT:  return (m_esub << 22) | (m_ecode << 16) | (32'(m_ti) << 11) | m_estat_is;
            `CSR_ERA:    return m_era;
            `CSR_BADV:   return m_badv;
            `CSR_EENTRY: return m_eentry;
            `CSR_SAVE0, `CSR_SAVE1, `CSR_SAVE2, `CSR_SAVE3:
                return m_save[num[1:0]];
            `CSR_TID:    return m_tid;
            `CSR_TCFG:   return m_tcfg;
            default:     return '0;  // tval is only read while the timer is off
        endcase
    endfunction

    task automatic apply_model(input csr_op_e op, input logic [13:0] num, input logic [31:0] wd,
                               input logic [31:0] pc, input logic [31:0] badv,
                               input logic [5:0] ecode, input logic [8:0] esub);
        if (op == OP_EXCP)
        begin
            m_prmd  = m_crmd & 32'h7;
            m_crmd  = m_crmd & ~32'h7;
            m_era   = pc;
            m_ecode = 32'(ecode);
            m_esub  = 32'(esub);
            if (ecode == `ECODE_ADE || ecode == `ECODE_ALE)
                m_badv = badv;
        end
        else if (op == OP_ERTN)
            m_crmd = (m_crmd & ~32'h7) | m_prmd;
        else if (op == OP_WR || op == OP_XCHG)
        begin
            case (num)
                `CSR_CRMD:   m_crmd = wd & 32'h1ff;
                `CSR_PRMD:   m_prmd = wd & 32'h7;
                `CSR_ECFG:   m_ecfg = wd & 32'h1bff;
                `CSR_ESTAT:  m_estat_is = wd & 32'h3;  // sw bits only
                `CSR_ERA:    m_era = wd;
                `CSR_BADV:   m_badv = wd;
                `CSR_EENTRY: m_eentry = wd & 32'hffff_ffc0;
                `CSR_SAVE0, `CSR_SAVE1, `CSR_SAVE2, `CSR_SAVE3:
                    m_save[num[1:0]] = wd;
                `CSR_TID:    m_tid = wd;
                `CSR_TCFG:   m_tcfg = wd;
                `CSR_TICLR:  if (wd[0]) m_ti = 1'b0;
                default:     ;
            endcase
        end
    endtask

    // one request, then an idle cycle while the entry commits
    task automatic send_and_check(input csr_req_t r, input logic stalled);
        logic [13:0]   num;
        logic [31:0]   old;
        logic [31:0]   mask;
        logic [31:0]   merged;
        logic [31:0]   exp_rdata;
        csr_redirect_t exp_redir;
        num              = r.arg.num.csr_num;
        old              = model_read(num);
        mask             = (r.op == OP_WR) ? '1 : r.mask;
        merged           = (r.wdata & mask) | (old & ~mask);
        exp_redir.flush  = !stalled && (r.op != OP_RD);
        exp_redir.target = r.pc + 4;
        exp_rdata        = '0;
        if (!stalled && (r.op == OP_RD || r.op == OP_XCHG))
            exp_rdata = old;
        if (!stalled && r.op == OP_EXCP)
            exp_redir.target = m_eentry;
        if (!stalled && r.op == OP_ERTN)
            exp_redir.target = m_era;
        req   = r;
        stall = stalled;
        @(posedge clk);
        #10;
        req.valid = 1'b0;
        stall     = 1'b0;
        compare_redirect("redirect", redirect, exp_redir);
        compare_data("rdata", rdata, exp_rdata);
        compare_flag("excp_flush", excp_flush, !stalled && r.op == OP_EXCP);
        compare_flag("ertn_flush", ertn_flush, !stalled && r.op == OP_ERTN);
        if (!stalled)
            apply_model(r.op, num, merged, r.pc, r.badv, r.arg.excp.ecode, r.arg.excp.esubcode);
        @(posedge clk);
        #10;
        compare_data("crmd", crmd, m_crmd);
    endtask

    task automatic random_request();
        csr_req_t   r;
        logic [2:0] sel;
        logic [1:0] cause;
        r        = '0;
        r.valid  = 1'b1;
        r.wdata  = $urandom;
        r.mask   = $urandom;
        r.pc     = $urandom;
        r.badv   = $urandom;
        sel      = 3'($urandom);
        if ($urandom % 8 == 0)
            r.arg.num.csr_num = 14'h100 | 14'($urandom);  // outside the kept set
        else
            r.arg.num.csr_num = KEPT_NUMS[$urandom % 15];
        // IE and timer enable stay off, interrupts belong to the timer test
        if (r.arg.num.csr_num == `CSR_CRMD || r.arg.num.csr_num == `CSR_PRMD)
            r.wdata[2] = 1'b0;
        if (r.arg.num.csr_num == `CSR_TCFG)
            r.wdata[0] = 1'b0;
        case (sel)
            3'd0, 3'd1:       r.op = OP_RD;
            3'd2, 3'd3, 3'd7: r.op = OP_WR;
            3'd4:             r.op = OP_XCHG;
            3'd5:             r.op = OP_EXCP;
            default:          r.op = OP_ERTN;
        endcase
        if (r.op == OP_EXCP)
        begin
            cause = 2'($urandom % 3);
            r.arg.excp.ecode = (cause == 0) ? `ECODE_SYS : (cause == 1) ? `ECODE_ADE : `ECODE_ALE;
            r.arg.excp.esubcode = 9'($urandom);
        end
        send_and_check(r, sel == 3'd7);
    endtask

    task automatic run_timer_test();
        csr_req_t      r;
        csr_redirect_t exp_redir;
        int            waited;
        logic          seen;
        r                 = '0;
        r.valid           = 1'b1;
        r.pc              = 32'h1c00_0100;
        r.op              = OP_WR;
        r.arg.num.csr_num = `CSR_TCFG;
        r.wdata           = 32'(TIMER_INIT) | 32'h1;  // enabled, one-shot
        send_and_check(r, 1'b0);
        r.arg.num.csr_num = `CSR_ECFG;
        r.wdata           = 32'h800;  // timer line only
        send_and_check(r, 1'b0);
        r.arg.num.csr_num = `CSR_CRMD;
        r.wdata           = m_crmd | 32'h4;
        send_and_check(r, 1'b0);
        req.pc = IDLE_PC;
        seen   = 1'b0;
        waited = 0;
        while (!seen && waited < TIMER_INIT + 8)
        begin
            @(posedge clk);
            #10;
            seen   = excp_flush;
            waited = waited + 1;
        end
        if (!seen)
        begin
            $display("no timer interrupt within %0d cycles", TIMER_INIT + 8);
            abort_run();
        end
        exp_redir.flush  = 1'b1;
        exp_redir.target = m_eentry;
        compare_redirect("redirect", redirect, exp_redir);
        compare_data("rdata", rdata, '0);
        compare_flag("ertn_flush", ertn_flush, 1'b0);
        m_ti = 1'b1;
        apply_model(OP_EXCP, '0, '0, IDLE_PC, '0, `ECODE_INT, '0);
        @(posedge clk);
        #10;
        compare_data("crmd", crmd, m_crmd);
        r.op              = OP_RD;
        r.arg.num.csr_num = `CSR_ESTAT;
        send_and_check(r, 1'b0);
        r.op              = OP_WR;
        r.arg.num.csr_num = `CSR_TICLR;
        r.wdata           = 32'h1;
        send_and_check(r, 1'b0);
        r.op              = OP_RD;
        r.arg.num.csr_num = `CSR_ESTAT;
        send_and_check(r, 1'b0);
        r.op = OP_ERTN;  // back to IDLE_PC with IE restored
        send_and_check(r, 1'b0);
        repeat (20)
        begin
            @(posedge clk);
            #10;
            compare_flag("excp_flush", excp_flush, 1'b0);
        end
    endtask

    initial
    begin
        void'($urandom(32'h916bd53d));
        clk   = 1'b0;
        rstn  = 1'b0;
        stall = 1'b0;
        req   = '0;
        repeat (16) @(posedge clk);
        #10;
        rstn = 1'b1;
        compare_flag("redirect.flush", redirect.flush, 1'b0);
        compare_flag("excp_flush", excp_flush, 1'b0);
        compare_flag("ertn_flush", ertn_flush, 1'b0);
        compare_data("crmd", crmd, m_crmd);
        for (int i = 0; i < NUM_REQ; i++)
            random_request();
        run_timer_test();
        $display("TEST OK");
        $finish;
    end

endmodule
